//--- rtl/video_pkg.sv
// Video-side types for the capture path, from the input pins to the pair FIFO.
// Referenced by scoped name from the producer, the FIFO, the consumer and the top level.

package video_pkg;

    // One colour channel
    localparam int CH_W = 8;

    // One RGB888 pixel
    localparam int PIXEL_W = 3 * CH_W;

    typedef struct packed {
        logic [CH_W-1:0] red;
        logic [CH_W-1:0] green;
        logic [CH_W-1:0] blue;
    } rgb_t;

    // Parallel video input pins, DPI style
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
        rgb_t pixel;
    } video_in_t;

    // One buffered item, two adjacent pixels of a line
    // The earlier pixel sits in the upper half
    typedef struct packed {
        logic sof;
        rgb_t first;
        rgb_t second;
    } pixel_pair_t;

endpackage

//--- rtl/bus_pkg.sv
// Wishbone-side types for the frame buffer write port.
// Referenced by scoped name from the consumer, the top level and the testbench.

package bus_pkg;

    // Word address into the frame buffer
    localparam int ADR_W = 24;

    // One bus word carries one pixel pair
    localparam int DAT_W = 48;

    // Signals driven by the master, classic cycles only
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat;
    } wb_m2s_t;

endpackage

//--- rtl/dpi_pixel_pair.sv
// Video producer. Registers the DPI pins, drops the start-up frames and emits
// one pixel pair per two pixels, resynchronising on every rising edge of de.

module dpi_pixel_pair #(
    parameter int SKIP_FRAMES = 3
) (
    input  logic                   pclk,
    input  logic                   vi_rst,
    input  video_pkg::video_in_t   vin,
    output video_pkg::pixel_pair_t pair,
    output logic                   pair_valid
);

    // One spare state so a skip count of zero still has a legal width
    localparam int SKIP_W = $clog2(SKIP_FRAMES + 2);

    video_pkg::video_in_t   vin_q;
    logic                   vsync_d;
    logic                   de_d;
    logic                   vsync_rise;
    logic                   de_rise;
    logic [SKIP_W-1:0]      skip_cnt;
    logic                   capture;
    logic                   sof_armed;
    logic                   phase;
    logic                   hold;
    logic                   emit;
    video_pkg::rgb_t        first_px;
    video_pkg::pixel_pair_t stage;
    logic                   stage_valid;

    // Input pins are registered once, then delayed by one more cycle for edges
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            vin_q   <= '0;
            vsync_d <= 1'b0;
            de_d    <= 1'b0;
        end else begin
            vin_q   <= vin;
            vsync_d <= vin_q.vsync;
            de_d    <= vin_q.de;
        end
    end

    assign vsync_rise = vin_q.vsync && !vsync_d;
    assign de_rise    = vin_q.de && !de_d;

    // First pixel of a pair, either at the start of active video or after a pair
    assign hold = vin_q.de && (de_rise || !phase);
    assign emit = capture && vin_q.de && phase && !de_rise;

    // Frame gate
    // Start-up frames only count down; later vsync edges arm sof
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            skip_cnt  <= SKIP_W'(SKIP_FRAMES);
            capture   <= 1'b0;
            sof_armed <= 1'b0;
        end else if (vsync_rise) begin
            if (skip_cnt != '0) begin
                skip_cnt <= skip_cnt - SKIP_W'(1);
            end else begin
                capture   <= 1'b1;
                sof_armed <= 1'b1;
            end
        end else if (emit) begin
            sof_armed <= 1'b0;
        end
    end

    // Pair phase, an odd last pixel is dropped when de falls
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            phase       <= 1'b0;
            stage_valid <= 1'b0;
            pair_valid  <= 1'b0;
        end else begin
            phase       <= hold;
            stage_valid <= emit;
            pair_valid  <= stage_valid;
        end
    end

    always_ff @(posedge pclk) begin
        if (hold) begin
            first_px <= vin_q.pixel;
        end
        if (emit) begin
            stage.sof    <= sof_armed;
            stage.first  <= first_px;
            stage.second <= vin_q.pixel;
        end
        // Output stage, lines up with pair_valid
        pair <= stage;
    end

    // The FIFO relies on at most one push every other cycle
    a_pair_spacing: assert property (
        @(posedge pclk) disable iff (vi_rst)
        pair_valid |=> !pair_valid
    ) else $error("pair_valid high on two consecutive cycles");

endmodule

//--- rtl/pair_fifo.sv
// Synchronous FIFO of pixel pairs between the video producer and the bus master.
// Pushes that find it full are lost and latch overflow until reset.

module pair_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   pclk,
    input  logic                   vi_rst,
    input  video_pkg::pixel_pair_t pair,
    input  logic                   pair_valid,
    output video_pkg::pixel_pair_t head,
    output logic                   not_empty,
    input  logic                   pop,
    output logic                   overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;

    video_pkg::pixel_pair_t mem [FIFO_DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [CW-1:0]          count;
    logic                   full;
    logic                   push;

    assign full      = (count == CW'(FIFO_DEPTH));
    assign push      = pair_valid && !full;
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr] <= pair;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Live video cannot wait, so a refused push is a lost pair
            if (pair_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (
        @(posedge pclk) disable iff (vi_rst)
        pop |-> not_empty
    ) else $error("pop while FIFO is empty");

endmodule

//--- rtl/frame_writer.sv
// Wishbone classic master that writes pixel pairs into the frame buffer.
// A pair flagged sof restarts at the base address, any other goes to the next word.

module frame_writer #(
    parameter logic [bus_pkg::ADR_W-1:0] FB_BASE = 24'h001000
) (
    input  logic                   pclk,
    input  logic                   vi_rst,
    input  video_pkg::pixel_pair_t head,
    input  logic                   not_empty,
    output logic                   pop,
    output bus_pkg::wb_m2s_t       wb,
    input  logic                   ack
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t                    state;
    logic                      take;
    logic [bus_pkg::ADR_W-1:0] adr_q;
    logic [bus_pkg::DAT_W-1:0] dat_q;

    // Take the head when idle, or right at ack for a back-to-back write
    assign take = not_empty && ((state == ST_IDLE) || ((state == ST_WRITE) && ack));

    // Head leaves the FIFO on the edge that loads the bus registers
    assign pop = take;

    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            state <= ST_IDLE;
            adr_q <= FB_BASE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (ack && !take) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (take) begin
                adr_q <= head.sof ? FB_BASE : adr_q + 1'b1;
            end
        end
    end

    // Earlier pixel in the upper half of the word
    always_ff @(posedge pclk) begin
        if (take) begin
            dat_q <= {head.first, head.second};
        end
    end

    // Write-only master, cyc and stb always move together
    assign wb.cyc = (state == ST_WRITE);
    assign wb.stb = (state == ST_WRITE);
    assign wb.we  = (state == ST_WRITE);
    assign wb.adr = adr_q;
    assign wb.dat = dat_q;

    // Slave may stretch the cycle with wait states
    a_hold_until_ack: assert property (
        @(posedge pclk) disable iff (vi_rst)
        (wb.stb && !ack) |=> ($stable(wb.adr) && $stable(wb.dat))
    ) else $error("adr or dat changed before ack");

endmodule

//--- rtl/video_capture_top.sv
// Video capture subsystem. Pixel pairs go from the DPI input through a FIFO
// to a Wishbone frame buffer writer; all parameters are set here.

module video_capture_top #(
    parameter int                        SKIP_FRAMES = 3,
    parameter int                        FIFO_DEPTH  = 16,
    parameter logic [bus_pkg::ADR_W-1:0] FB_BASE     = 24'h001000
) (
    input  logic                 pclk,
    input  logic                 vi_rst,
    input  video_pkg::video_in_t vin,
    output bus_pkg::wb_m2s_t     wb,
    input  logic                 ack,
    output logic                 overflow
);

    video_pkg::pixel_pair_t pair;
    logic                   pair_valid;
    video_pkg::pixel_pair_t head;
    logic                   not_empty;
    logic                   pop;

    dpi_pixel_pair #(
        .SKIP_FRAMES (SKIP_FRAMES)
    ) u_dpi_pixel_pair (
        .pclk       (pclk),
        .vi_rst     (vi_rst),
        .vin        (vin),
        .pair       (pair),
        .pair_valid (pair_valid)
    );

    pair_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_pair_fifo (
        .pclk       (pclk),
        .vi_rst     (vi_rst),
        .pair       (pair),
        .pair_valid (pair_valid),
        .head       (head),
        .not_empty  (not_empty),
        .pop        (pop),
        .overflow   (overflow)
    );

    frame_writer #(
        .FB_BASE (FB_BASE)
    ) u_frame_writer (
        .pclk      (pclk),
        .vi_rst    (vi_rst),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .wb        (wb),
        .ack       (ack)
    );

endmodule

//--- verification/tb_video_capture.sv
// Testbench for the video capture subsystem. Drives DPI video frames from a table
// of rows, models the Wishbone frame memory and checks every write against a pair model.

module tb_video_capture;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                        CLK_PERIOD  = 40;
    localparam int                        SKIP_FRAMES = 2;
    localparam int                        FIFO_DEPTH  = 8;
    localparam logic [bus_pkg::ADR_W-1:0] FB_BASE     = 24'h001000;
    localparam int                        N_ROWS      = 7;
    localparam int                        VS_HIGH     = 3;
    localparam int                        VS_PORCH    = 10;
    localparam int                        HS_WIDTH    = 4;

    // One frame of stimulus
    typedef struct packed {
        int   lines;
        int   ppl;
        int   ack_dly;
        logic exp_ovf;
    } row_t;

    logic                 pclk     = 1'b0;
    logic                 vi_rst   = 1'b1;
    video_pkg::video_in_t vin      = '0;
    logic                 ack      = 1'b0;
    bus_pkg::wb_m2s_t     wb;
    logic                 overflow;

    row_t                      rows [N_ROWS];
    logic [31:0]               lcg_state = 32'h86d5_75ce;
    int                        cur_dly   = 0;
    int                        wait_cnt  = 0;
    int                        errors    = 0;
    int                        rows_pass = 0;
    int                        rows_fail = 0;
    logic [bus_pkg::ADR_W-1:0] got_adr [$];
    logic [bus_pkg::DAT_W-1:0] got_dat [$];
    logic [bus_pkg::ADR_W-1:0] exp_adr [$];
    logic [bus_pkg::DAT_W-1:0] exp_dat [$];

    video_capture_top #(
        .SKIP_FRAMES (SKIP_FRAMES),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .FB_BASE     (FB_BASE)
    ) u_video_capture_top (
        .pclk     (pclk),
        .vi_rst   (vi_rst),
        .vin      (vin),
        .wb       (wb),
        .ack      (ack),
        .overflow (overflow)
    );

    always #(CLK_PERIOD / 2) pclk = ~pclk;

    // Frame memory, acks each write after cur_dly wait states and logs it
    always @(posedge pclk) begin
        if (ack) begin
            ack <= 1'b0;
        end else if (wb.cyc && wb.stb && wb.we) begin
            if (wait_cnt >= cur_dly) begin
                ack      <= 1'b1;
                wait_cnt <= 0;
                got_adr.push_back(wb.adr);
                got_dat.push_back(wb.dat);
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    function automatic logic [23:0] next_pixel();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:8];
    endfunction

    // Long enough for the bus to drain a whole line of pairs
    function automatic int blank_cycles(row_t r);
        return 20 + (r.ppl / 2) * (r.ack_dly + 2);
    endfunction

    function automatic int frame_cycles(row_t r);
        return VS_HIGH + VS_PORCH + r.lines * (r.ppl + blank_cycles(r));
    endfunction

    task automatic compare_value(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic drive_pins(logic vs, logic hs, logic de, video_pkg::rgb_t px);
        @(posedge pclk);
        vin.vsync <= vs;
        vin.hsync <= hs;
        vin.de    <= de;
        vin.pixel <= px;
    endtask

    // Drives one frame and appends the writes it should cause
    task automatic send_frame(int f, row_t r);
        video_pkg::rgb_t           line_px [$];
        video_pkg::rgb_t           px;
        logic [bus_pkg::ADR_W-1:0] adr;
        int                        idx;
        idx = 0;
        adr = FB_BASE;
        for (int i = 0; i < VS_HIGH; i++) begin
            drive_pins(1'b1, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < VS_PORCH; i++) begin
            drive_pins(1'b0, 1'b0, 1'b0, '0);
        end
        for (int l = 0; l < r.lines; l++) begin
            line_px.delete();
            for (int p = 0; p < r.ppl; p++) begin
                px = next_pixel();
                line_px.push_back(px);
                drive_pins(1'b0, 1'b0, 1'b1, px);
            end
            for (int b = 0; b < blank_cycles(r); b++) begin
                drive_pins(1'b0, (b < HS_WIDTH), 1'b0, '0);
            end
            // Pairs start again at each line, an odd last pixel is lost
            // A slow bus keeps only FIFO_DEPTH pairs plus the one on the bus
            if (f >= SKIP_FRAMES) begin
                for (int k = 0; k < r.ppl / 2; k++) begin
                    if (!r.exp_ovf || k <= FIFO_DEPTH) begin
                        adr = (idx == 0) ? FB_BASE : adr + 1'b1;
                        exp_adr.push_back(adr);
                        exp_dat.push_back({line_px[2*k], line_px[2*k+1]});
                        idx++;
                    end
                end
            end
        end
    endtask

    task automatic run_row(int f);
        row_t r;
        int   err_before;
        int   quiet;
        r          = rows[f];
        err_before = errors;
        cur_dly    = r.ack_dly;
        got_adr.delete();
        got_dat.delete();
        exp_adr.delete();
        exp_dat.delete();
        send_frame(f, r);
        // Bus is drained once cyc stays low over two edges
        quiet = 0;
        while (quiet < 2) begin
            @(posedge pclk);
            quiet = wb.cyc ? 0 : quiet + 1;
        end
        compare_value("write_count", 64'(exp_adr.size()), 64'(got_adr.size()));
        for (int i = 0; i < exp_adr.size() && i < got_adr.size(); i++) begin
            compare_value($sformatf("wb.adr[%0d]", i), 64'(exp_adr[i]), 64'(got_adr[i]));
            compare_value($sformatf("wb.dat[%0d]", i), 64'(exp_dat[i]), 64'(got_dat[i]));
        end
        compare_value("overflow", 64'(r.exp_ovf), 64'(overflow));
        if (errors == err_before) begin
            rows_pass++;
        end else begin
            rows_fail++;
        end
        $display("row %0d: lines %0d px %0d ack_dly %0d writes %0d %s", f, r.lines, r.ppl,
                 r.ack_dly, got_adr.size(), (errors == err_before) ? "pass" : "mismatch");
    endtask

    initial begin
        int total;
        // Rows 0 and 1 are start-up frames, the last one overruns the FIFO
        rows[0] = '{lines: 2, ppl: 6,  ack_dly: 0,  exp_ovf: 1'b0};
        rows[1] = '{lines: 2, ppl: 5,  ack_dly: 1,  exp_ovf: 1'b0};
        rows[2] = '{lines: 3, ppl: 8,  ack_dly: 0,  exp_ovf: 1'b0};
        rows[3] = '{lines: 3, ppl: 7,  ack_dly: 2,  exp_ovf: 1'b0};
        rows[4] = '{lines: 4, ppl: 12, ack_dly: 6,  exp_ovf: 1'b0};
        rows[5] = '{lines: 2, ppl: 9,  ack_dly: 3,  exp_ovf: 1'b0};
        rows[6] = '{lines: 2, ppl: 40, ack_dly: 50, exp_ovf: 1'b1};
        total = 0;
        for (int f = 0; f < N_ROWS; f++) begin
            total += frame_cycles(rows[f]);
        end
        fork
            begin
                #((total * 2 + 2000) * CLK_PERIOD);
                $display("timeout: the bus did not go idle within the expected run time");
                $display("Test FAILED");
                $finish;
            end
        join_none
        repeat (10) @(posedge pclk);
        vi_rst <= 1'b0;
        for (int f = 0; f < N_ROWS; f++) begin
            run_row(f);
        end
        $display("rows passed %0d, rows failed %0d, errors %0d", rows_pass, rows_fail, errors);
        if (errors == 0 && rows_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/video_pkg.sv
rtl/bus_pkg.sv
rtl/dpi_pixel_pair.sv
rtl/pair_fifo.sv
rtl/frame_writer.sv
rtl/video_capture_top.sv
verification/tb_video_capture.sv

//--- Makefile
# Verilator build and run of the video capture testbench

SIM := obj_dir/Vtb_video_capture

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(SIM): src.f $(wildcard rtl/*.sv verification/*.sv)
	verilator --binary --timing --assert -j 0 \
		--top-module tb_video_capture -f src.f -o Vtb_video_capture

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
